//--- build.f
hdl/priv_pkg.sv
hdl/csr_file.sv
hdl/intr_arbiter.sv
hdl/trap_ctrl.sv
hdl/priv_unit.sv
verif/priv_unit_checker.sv
verif/priv_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents
rm -f sim.log
verilator --binary --timing --top-module priv_unit_tb -f build.f -o priv_unit_sim || exit 1
./obj_dir/priv_unit_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "run_sim: passed" || { echo "run_sim: failed"; exit 1; }

//--- verif/priv_unit_tb.sv
module priv_unit_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import priv_pkg::*;

   localparam xlen_t HART      = 32'h0000_0003;
   localparam int    ROW_LIMIT = 20;

   typedef enum logic [2:0] {EV_CSR, EV_EXC, EV_MRET, EV_SRET, EV_BOUNDARY} event_t;

   typedef struct {
      event_t     kind;
      csr_op_t    op;
      csr_addr_t  addr;
      xlen_t      data;      // csr wdata or exception tval
      cause_t     cause;
      xlen_t      pc;        // exc_pc, ret_pc or boundary_pc
      logic       ext;
      logic       timer;
      xlen_t      exp_rdata;
      logic       exp_illegal;
      logic       exp_redir;
      xlen_t      exp_pc;
      priv_mode_t exp_mode;
      xlen_t      exp_satp;
      logic       exp_mxr;
      logic       exp_sum;
   } row_t;

   logic       clk;
   logic       rstn;
   logic       csr_valid;
   csr_op_t    csr_op;
   csr_addr_t  csr_addr;
   xlen_t      csr_wdata;
   logic       csr_done;
   xlen_t      csr_rdata;
   logic       csr_illegal;
   logic       exc_valid;
   cause_t     exc_cause;
   xlen_t      exc_tval;
   xlen_t      exc_pc;
   logic       mret_valid;
   logic       sret_valid;
   xlen_t      ret_pc;
   logic       boundary_valid;
   xlen_t      boundary_pc;
   logic       ext_intr;
   logic       timer_intr;
   logic       redirect_valid;
   xlen_t      redirect_pc;
   priv_mode_t cpu_mode;
   xlen_t      satp;
   logic       mxr;
   logic       sum;

   // expectations handed to the checker
   logic       start;
   int         row_num;
   logic       is_csr;
   xlen_t      exp_rdata;
   logic       exp_illegal;
   logic       exp_redir;
   xlen_t      exp_pc;
   priv_mode_t exp_mode;
   xlen_t      exp_satp;
   logic       exp_mxr;
   logic       exp_sum;
   int         rows_checked;
   int         mismatches;
   int         timeouts;
   int         tb_timeouts;

   row_t  table_q[$];
   // interrupt levels and status outputs that new rows inherit
   logic  cur_ext;
   logic  cur_timer;
   xlen_t cur_satp;
   logic  cur_mxr;
   logic  cur_sum;

   priv_unit #(
      .HART_ID (HART)
   ) i_priv_unit (
      .*
   );

   priv_unit_checker i_priv_unit_checker (
      .*
   );

   always #10 clk = ~clk;

   //////////////////////////////////////////////////
   // table construction

   function automatic row_t base_row(input event_t kind, input priv_mode_t mode);
      row_t r;
      r.kind        = kind;
      r.op          = CSR_RW;
      r.addr        = '0;
      r.data        = '0;
      r.cause       = '0;
      r.pc          = '0;
      r.ext         = cur_ext;
      r.timer       = cur_timer;
      r.exp_rdata   = '0;
      r.exp_illegal = 1'b0;
      r.exp_redir   = 1'b0;
      r.exp_pc      = '0;
      r.exp_mode    = mode;
      r.exp_satp    = cur_satp;
      r.exp_mxr     = cur_mxr;
      r.exp_sum     = cur_sum;
      return r;
   endfunction

   task automatic csr_step(input csr_op_t op, input csr_addr_t addr, input xlen_t wdata,
                           input xlen_t rdata, input logic illegal, input priv_mode_t mode);
      row_t r;
      r             = base_row(EV_CSR, mode);
      r.op          = op;
      r.addr        = addr;
      r.data        = wdata;
      r.exp_rdata   = rdata;
      r.exp_illegal = illegal;
      table_q.push_back(r);
   endtask

   task automatic exception_step(input cause_t cause, input xlen_t tval, input xlen_t pc,
                                 input xlen_t target, input priv_mode_t mode);
      row_t r;
      r           = base_row(EV_EXC, mode);
      r.cause     = cause;
      r.data      = tval;
      r.pc        = pc;
      r.exp_redir = 1'b1;
      r.exp_pc    = target;
      table_q.push_back(r);
   endtask

   // mret or sret, always redirected somewhere
   task automatic return_step(input event_t kind, input xlen_t pc, input xlen_t target,
                              input priv_mode_t mode);
      row_t r;
      r           = base_row(kind, mode);
      r.pc        = pc;
      r.exp_redir = 1'b1;
      r.exp_pc    = target;
      table_q.push_back(r);
   endtask

   task automatic boundary_step(input xlen_t pc, input logic redir, input xlen_t target,
                                input priv_mode_t mode);
      row_t r;
      r           = base_row(EV_BOUNDARY, mode);
      r.pc        = pc;
      r.exp_redir = redir;
      r.exp_pc    = target;
      table_q.push_back(r);
   endtask

   task automatic build_table(input xlen_t r0, input xlen_t r1);
      cur_ext   = 1'b0;
      cur_timer = 1'b0;
      cur_satp  = '0;
      cur_mxr   = 1'b0;
      cur_sum   = 1'b0;
      boundary_step(32'h100, 1'b0, '0, PRIV_M);
      // scratch read-modify-write, masks, hart id
      csr_step(CSR_RW, CSR_MSCRATCH, r0, '0, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MSCRATCH, r1, r0, 1'b0, PRIV_M);
      csr_step(CSR_RC, CSR_MSCRATCH, r0, r0 | r1, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MSCRATCH, '0, (r0 | r1) & ~r0, 1'b0, PRIV_M);
      csr_step(CSR_RW, CSR_MIE, 32'hffff_ffff, '0, 1'b0, PRIV_M);
      csr_step(CSR_RW, CSR_MIE, '0, 32'h0000_0aaa, 1'b0, PRIV_M);
      csr_step(CSR_RW, CSR_MEDELEG, 32'hffff_ffff, '0, 1'b0, PRIV_M);
      csr_step(CSR_RW, CSR_MEDELEG, 32'h0000_0100, 32'h0000_bfff, 1'b0, PRIV_M);
      csr_step(CSR_RW, CSR_MIDELEG, 32'hffff_ffff, '0, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MIDELEG, '0, 32'h0000_0222, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MHARTID, '0, HART, 1'b0, PRIV_M);
      // unknown address, traps to M with epc 0x100
      csr_step(CSR_RS, 12'h7c0, '0, '0, 1'b1, PRIV_M);
      cur_mxr = 1'b1;
      cur_sum = 1'b1;
      csr_step(CSR_RW, CSR_MSTATUS, 32'h001c_0800, 32'h0000_1800, 1'b0, PRIV_M);
      csr_step(CSR_RW, CSR_MEPC, 32'h0000_2000, 32'h0000_0100, 1'b0, PRIV_M);
      return_step(EV_MRET, 32'h40, 32'h0000_2000, PRIV_S);
      // satp under TVM
      csr_step(CSR_RW, CSR_SATP, 32'h8000_1234, '0, 1'b1, PRIV_M);
      cur_satp = 32'h8000_1234;
      csr_step(CSR_RW, CSR_SATP, 32'h8000_1234, '0, 1'b0, PRIV_M);
      // exception entry, direct target even with vectored mtvec
      csr_step(CSR_RW, CSR_MTVEC, 32'h0000_8001, '0, 1'b0, PRIV_M);
      exception_step(5'd3, 32'hdead_beef, 32'h400, 32'h0000_8000, PRIV_M);
      csr_step(CSR_RS, CSR_MEPC, '0, 32'h0000_0400, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MCAUSE, '0, 32'h0000_0003, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MTVAL, '0, 32'hdead_beef, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MSTATUS, '0, 32'h001c_1800, 1'b0, PRIV_M);
      csr_step(CSR_RC, CSR_MSTATUS, 32'h0000_1800, 32'h001c_1800, 1'b0, PRIV_M);
      csr_step(CSR_RW, CSR_STVEC, 32'h0000_4000, '0, 1'b0, PRIV_M);
      return_step(EV_MRET, 32'h404, 32'h0000_0400, PRIV_U);
      exception_step(5'd8, '0, 32'h500, 32'h0000_4000, PRIV_S);
      return_step(EV_SRET, 32'h504, 32'h0000_0500, PRIV_U);
      // sret from U is an illegal instruction
      return_step(EV_SRET, 32'h600, 32'h0000_8000, PRIV_M);
      csr_step(CSR_RS, CSR_MEPC, '0, 32'h0000_0600, 1'b0, PRIV_M);
      csr_step(CSR_RS, CSR_MCAUSE, '0, 32'h0000_0002, 1'b0, PRIV_M);
      // interrupts
      csr_step(CSR_RW, CSR_MIE, 32'h0000_0080, '0, 1'b0, PRIV_M);
      return_step(EV_MRET, 32'h604, 32'h0000_0600, PRIV_U);
      cur_timer = 1'b1;
      boundary_step(32'h700, 1'b1, 32'h0000_801c, PRIV_M);
      csr_step(CSR_RS, CSR_MCAUSE, '0, 32'h8000_0007, 1'b0, PRIV_M);
      boundary_step(32'h704, 1'b0, '0, PRIV_M);
      cur_timer = 1'b0;
      csr_step(CSR_RS, CSR_MIE, 32'h0000_0200, 32'h0000_0080, 1'b0, PRIV_M);
      return_step(EV_MRET, 32'h708, 32'h0000_0700, PRIV_U);
      cur_ext = 1'b1;
      boundary_step(32'h800, 1'b1, 32'h0000_4000, PRIV_S);
      cur_ext = 1'b0;
      csr_step(CSR_RS, CSR_SCAUSE, '0, 32'h8000_0009, 1'b0, PRIV_S);
   endtask

   //////////////////////////////////////////////////
   // driving

   task automatic clear_pulses();
      csr_valid      = 1'b0;
      exc_valid      = 1'b0;
      mret_valid     = 1'b0;
      sret_valid     = 1'b0;
      boundary_valid = 1'b0;
      start          = 1'b0;
   endtask

   task automatic apply_row(input row_t r, input int idx);
      csr_valid      = (r.kind == EV_CSR);
      csr_op         = r.op;
      csr_addr       = r.addr;
      csr_wdata      = r.data;
      exc_valid      = (r.kind == EV_EXC);
      exc_cause      = r.cause;
      exc_tval       = r.data;
      exc_pc         = r.pc;
      mret_valid     = (r.kind == EV_MRET);
      sret_valid     = (r.kind == EV_SRET);
      ret_pc         = r.pc;
      boundary_valid = (r.kind == EV_BOUNDARY);
      boundary_pc    = r.pc;
      ext_intr       = r.ext;
      timer_intr     = r.timer;
      row_num        = idx;
      is_csr         = (r.kind == EV_CSR);
      exp_rdata      = r.exp_rdata;
      exp_illegal    = r.exp_illegal;
      exp_redir      = r.exp_redir;
      exp_pc         = r.exp_pc;
      exp_mode       = r.exp_mode;
      exp_satp       = r.exp_satp;
      exp_mxr        = r.exp_mxr;
      exp_sum        = r.exp_sum;
      start          = 1'b1;
   endtask

   // returns 0 when the checker never finished the row
   task automatic wait_checked(input int target, output logic ok);
      int n;
      n = 0;
      while (rows_checked < target && n < ROW_LIMIT) begin
         @(posedge clk);
         n++;
      end
      ok = (rows_checked >= target);
      if (!ok) begin
         tb_timeouts++;
         $display("Timeout at %0t: checker did not finish row %0d", $time, target - 1);
      end
   endtask

   initial begin
      xlen_t r0;
      xlen_t r1;
      int    i;
      logic  ok;
      clk         = 1'b0;
      rstn        = 1'b1;
      tb_timeouts = 0;
      void'($urandom(32'ha13a_13df));
      r0 = $urandom();
      r1 = $urandom();
      build_table(r0, r1);
      clear_pulses();
      apply_row(base_row(EV_CSR, PRIV_M), -1);
      start = 1'b0;
      csr_valid = 1'b0;
      is_csr = 1'b0;

      repeat (3) @(posedge clk);
      #2 rstn = 1'b0;

      i  = 0;
      ok = 1'b1;
      while (i < table_q.size() && ok) begin
         @(posedge clk);
         #2;
         apply_row(table_q[i], i);
         @(posedge clk);
         #2;
         clear_pulses();
         wait_checked(i + 1, ok);
         i++;
      end

      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts + tb_timeouts);
      if (mismatches == 0 && timeouts == 0 && tb_timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- verif/priv_unit_checker.sv
module priv_unit_checker (
   input  logic                 clk,
   input  logic                 start,
   input  int                   row_num,
   input  logic                 is_csr,
   input  priv_pkg::xlen_t      exp_rdata,
   input  logic                 exp_illegal,
   input  logic                 exp_redir,
   input  priv_pkg::xlen_t      exp_pc,
   input  priv_pkg::priv_mode_t exp_mode,
   input  priv_pkg::xlen_t      exp_satp,
   input  logic                 exp_mxr,
   input  logic                 exp_sum,
   input  logic                 csr_done,
   input  priv_pkg::xlen_t      csr_rdata,
   input  logic                 csr_illegal,
   input  logic                 redirect_valid,
   input  priv_pkg::xlen_t      redirect_pc,
   input  priv_pkg::priv_mode_t cpu_mode,
   input  priv_pkg::xlen_t      satp,
   input  logic                 mxr,
   input  logic                 sum,
   output int                   rows_checked,
   output int                   mismatches,
   output int                   timeouts
);
   timeunit 1ns;
   timeprecision 100ps;
   import priv_pkg::*;

   // responses are due one cycle after the event
   localparam int RESP_LIMIT   = 8;
   localparam int QUIET_CYCLES = 3;

   task automatic compare(input string what, input xlen_t got, input xlen_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch at %0t: row %0d %s got %h expected %h",
                  $time, row_num, what, got, exp);
      end
   endtask

   //////////////////////////////////////////////////
   // per-kind response checks

   task automatic csr_response();
      int n;
      n = 0;
      @(negedge clk);
      while (!csr_done && n < RESP_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!csr_done) begin
         timeouts++;
         $display("Timeout at %0t: row %0d, csr_done never came", $time, row_num);
      end else begin
         compare("csr_rdata", csr_rdata, exp_rdata);
         compare("csr_illegal", xlen_t'(csr_illegal), xlen_t'(exp_illegal));
      end
   endtask

   task automatic redirect_response();
      int n;
      n = 0;
      @(negedge clk);
      while (!redirect_valid && n < RESP_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!redirect_valid) begin
         timeouts++;
         $display("Timeout at %0t: row %0d, no redirect within %0d cycles",
                  $time, row_num, RESP_LIMIT);
      end else begin
         compare("redirect_pc", redirect_pc, exp_pc);
      end
   endtask

   // no redirect may show up at all
   task automatic no_redirect();
      for (int i = 0; i < QUIET_CYCLES; i++) begin
         @(negedge clk);
         if (redirect_valid) begin
            mismatches++;
            $display("Mismatch at %0t: row %0d redirect_valid set, none expected",
                     $time, row_num);
         end
      end
   endtask

   // mode and csr side effects settle one edge after the response
   task automatic mode_and_status();
      @(negedge clk);
      compare("cpu_mode", xlen_t'(cpu_mode), xlen_t'(exp_mode));
      compare("satp", satp, exp_satp);
      compare("mxr", xlen_t'(mxr), xlen_t'(exp_mxr));
      compare("sum", xlen_t'(sum), xlen_t'(exp_sum));
   endtask

   initial begin
      rows_checked = 0;
      mismatches   = 0;
      timeouts     = 0;
      forever begin
         @(negedge clk);
         if (start) begin
            if (is_csr) begin
               csr_response();
            end else if (exp_redir) begin
               redirect_response();
            end else begin
               no_redirect();
            end
            mode_and_status();
            rows_checked++;
         end
      end
   end

endmodule

//--- hdl/priv_unit.sv
module priv_unit #(
   parameter priv_pkg::xlen_t HART_ID = 32'd0
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 csr_valid,
   input  priv_pkg::csr_op_t    csr_op,
   input  priv_pkg::csr_addr_t  csr_addr,
   input  priv_pkg::xlen_t      csr_wdata,
   output logic                 csr_done,
   output priv_pkg::xlen_t      csr_rdata,
   output logic                 csr_illegal,
   input  logic                 exc_valid,
   input  priv_pkg::cause_t     exc_cause,
   input  priv_pkg::xlen_t      exc_tval,
   input  priv_pkg::xlen_t      exc_pc,
   input  logic                 mret_valid,
   input  logic                 sret_valid,
   input  priv_pkg::xlen_t      ret_pc,
   input  logic                 boundary_valid,
   input  priv_pkg::xlen_t      boundary_pc,
   input  logic                 ext_intr,
   input  logic                 timer_intr,
   output logic                 redirect_valid,
   output priv_pkg::xlen_t      redirect_pc,
   output priv_pkg::priv_mode_t cpu_mode,
   output priv_pkg::xlen_t      satp,
   output logic                 mxr,
   output logic                 sum
);
   import priv_pkg::*;

   // csr state seen by the trap logic and the arbiter
   xlen_t      mtvec;
   xlen_t      stvec;
   xlen_t      mepc;
   xlen_t      sepc;
   xlen_t      medeleg;
   xlen_t      mip;
   xlen_t      mie;
   xlen_t      mideleg;
   logic       mstatus_mie;
   logic       mstatus_sie;
   priv_mode_t mstatus_mpp;
   logic       mstatus_spp;

   logic       irq_pending;
   cause_t     irq_code;
   logic       irq_to_s;

   // trap update into the csr file
   logic       trap_take;
   logic       trap_to_s;
   xlen_t      trap_cause;
   xlen_t      trap_tval;
   xlen_t      trap_epc;
   logic       xret_m;
   logic       xret_s;

   csr_file #(
      .HART_ID (HART_ID)
   ) i_csr_file (
      .mstatus_tvm (),
      .*
   );

   intr_arbiter i_intr_arbiter (
      .*
   );

   trap_ctrl i_trap_ctrl (
      .csr_illegal_evt (csr_illegal),
      .*
   );

endmodule

//--- hdl/trap_ctrl.sv
module trap_ctrl (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 exc_valid,
   input  priv_pkg::cause_t     exc_cause,
   input  priv_pkg::xlen_t      exc_tval,
   input  priv_pkg::xlen_t      exc_pc,
   input  logic                 mret_valid,
   input  logic                 sret_valid,
   input  priv_pkg::xlen_t      ret_pc,
   input  logic                 boundary_valid,
   input  priv_pkg::xlen_t      boundary_pc,
   input  logic                 csr_illegal_evt,
   input  logic                 irq_pending,
   input  priv_pkg::cause_t     irq_code,
   input  logic                 irq_to_s,
   input  priv_pkg::xlen_t      mtvec,
   input  priv_pkg::xlen_t      stvec,
   input  priv_pkg::xlen_t      mepc,
   input  priv_pkg::xlen_t      sepc,
   input  priv_pkg::xlen_t      medeleg,
   input  priv_pkg::priv_mode_t mstatus_mpp,
   input  logic                 mstatus_spp,
   output priv_pkg::priv_mode_t cpu_mode,
   output logic                 redirect_valid,
   output priv_pkg::xlen_t      redirect_pc,
   output logic                 trap_take,
   output logic                 trap_to_s,
   output priv_pkg::xlen_t      trap_cause,
   output priv_pkg::xlen_t      trap_tval,
   output priv_pkg::xlen_t      trap_epc,
   output logic                 xret_m,
   output logic                 xret_s
);
   import priv_pkg::*;

   xlen_t      last_pc;
   logic       redirect_q;
   xlen_t      redirect_pc_q;
   logic       illegal_now;
   logic       irq_take;
   logic       exc_take;
   cause_t     exc_code;
   xlen_t      exc_tv;
   xlen_t      exc_epc;
   xlen_t      tvec;
   xlen_t      tvec_base;
   xlen_t      trap_target;
   priv_mode_t mode_next;

   //////////////////////////////////////////////////
   // event selection: exception, mret, sret, boundary

   // a bad csr access only traps when nothing else is going on
   assign illegal_now = csr_illegal_evt
                     && !(exc_valid || mret_valid || sret_valid || boundary_valid);
   assign xret_m   = mret_valid && !exc_valid && cpu_mode == PRIV_M;
   assign xret_s   = sret_valid && !exc_valid && !mret_valid && cpu_mode != PRIV_U;
   assign irq_take = boundary_valid && irq_pending
                  && !(exc_valid || mret_valid || sret_valid);

   // returns from too low a mode fall back to illegal instruction
   always_comb begin
      exc_take = 1'b1;
      exc_code = exc_cause;
      exc_tv   = exc_tval;
      exc_epc  = exc_pc;
      if (!exc_valid) begin
         exc_code = CAUSE_ILLEGAL;
         exc_tv   = '0;
         exc_epc  = ret_pc;
         if (mret_valid) begin
            exc_take = cpu_mode != PRIV_M;
         end else if (sret_valid) begin
            exc_take = cpu_mode == PRIV_U;
         end else begin
            exc_take = illegal_now;
            exc_epc  = last_pc;
         end
      end
   end

   assign trap_take  = exc_take || irq_take;
   assign trap_to_s  = irq_take ? irq_to_s : (medeleg[exc_code] && cpu_mode != PRIV_M);
   assign trap_cause = irq_take ? {1'b1, 26'd0, irq_code} : {27'd0, exc_code};
   assign trap_tval  = irq_take ? '0 : exc_tv;
   assign trap_epc   = irq_take ? boundary_pc : exc_epc;

   // vectored mode only applies to interrupts
   assign tvec        = trap_to_s ? stvec : mtvec;
   assign tvec_base   = {tvec[31:2], 2'b00};
   assign trap_target = (irq_take && tvec[1:0] == 2'b01) ?
                        tvec_base + {25'd0, irq_code, 2'b00} : tvec_base;

   always_comb begin
      mode_next = cpu_mode;
      if (trap_take) begin
         mode_next = trap_to_s ? PRIV_S : PRIV_M;
      end else if (xret_m) begin
         mode_next = mstatus_mpp;
      end else if (xret_s) begin
         mode_next = mstatus_spp ? PRIV_S : PRIV_U;
      end
   end

   //////////////////////////////////////////////////
   // registered mode and redirect

   always_ff @(posedge clk) begin
      if (rstn) begin
         cpu_mode   <= PRIV_M;
         redirect_q <= 1'b0;
      end else begin
         cpu_mode   <= mode_next;
         redirect_q <= (trap_take && !illegal_now) || xret_m || xret_s;
      end
   end

   always_ff @(posedge clk) begin
      if (boundary_valid) begin
         last_pc <= boundary_pc;
      end
      if (xret_m) begin
         redirect_pc_q <= mepc;
      end else if (xret_s) begin
         redirect_pc_q <= sepc;
      end else begin
         redirect_pc_q <= trap_target;
      end
   end

   // the csr trap rides along with csr_done
   assign redirect_valid = redirect_q || illegal_now;
   assign redirect_pc    = illegal_now ? trap_target : redirect_pc_q;

endmodule

//--- hdl/intr_arbiter.sv
module intr_arbiter (
   input  priv_pkg::xlen_t      mip,
   input  priv_pkg::xlen_t      mie,
   input  priv_pkg::xlen_t      mideleg,
   input  logic                 mstatus_mie,
   input  logic                 mstatus_sie,
   input  priv_pkg::priv_mode_t cpu_mode,
   output logic                 irq_pending,
   output priv_pkg::cause_t     irq_code,
   output logic                 irq_to_s
);
   import priv_pkg::*;

   // fixed check order, external first
   localparam int IRQ_ORDER [4] = '{IRQ_SEI, IRQ_MSI, IRQ_SSI, IRQ_MTI};

   logic m_enabled;
   logic s_enabled;

   // M-level always fires below M
   assign m_enabled = (cpu_mode != PRIV_M) || mstatus_mie;
   // S-level never fires in M
   assign s_enabled = (cpu_mode == PRIV_U) || (cpu_mode == PRIV_S && mstatus_sie);

   always_comb begin
      irq_pending = 1'b0;
      irq_code    = '0;
      irq_to_s    = 1'b0;
      for (int i = 0; i < 4; i++) begin
         if (!irq_pending && mip[IRQ_ORDER[i]] && mie[IRQ_ORDER[i]]
             && (mideleg[IRQ_ORDER[i]] ? s_enabled : m_enabled)) begin
            irq_pending = 1'b1;
            irq_code    = cause_t'(IRQ_ORDER[i]);
            irq_to_s    = mideleg[IRQ_ORDER[i]];
         end
      end
   end

endmodule

//--- hdl/csr_file.sv
module csr_file #(
   parameter priv_pkg::xlen_t HART_ID = 32'd0
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 csr_valid,
   input  priv_pkg::csr_op_t    csr_op,
   input  priv_pkg::csr_addr_t  csr_addr,
   input  priv_pkg::xlen_t      csr_wdata,
   input  priv_pkg::priv_mode_t cpu_mode,
   input  logic                 ext_intr,
   input  logic                 timer_intr,
   input  logic                 trap_take,
   input  logic                 trap_to_s,
   input  priv_pkg::xlen_t      trap_cause,
   input  priv_pkg::xlen_t      trap_tval,
   input  priv_pkg::xlen_t      trap_epc,
   input  logic                 xret_m,
   input  logic                 xret_s,
   output logic                 csr_done,
   output priv_pkg::xlen_t      csr_rdata,
   output logic                 csr_illegal,
   output priv_pkg::xlen_t      mtvec,
   output priv_pkg::xlen_t      stvec,
   output priv_pkg::xlen_t      mepc,
   output priv_pkg::xlen_t      sepc,
   output priv_pkg::xlen_t      medeleg,
   output priv_pkg::xlen_t      mip,
   output priv_pkg::xlen_t      mie,
   output priv_pkg::xlen_t      mideleg,
   output logic                 mstatus_mie,
   output logic                 mstatus_sie,
   output logic                 mstatus_tvm,
   output priv_pkg::priv_mode_t mstatus_mpp,
   output logic                 mstatus_spp,
   output priv_pkg::xlen_t      satp,
   output logic                 mxr,
   output logic                 sum
);
   import priv_pkg::*;

   // bits that sstatus may change in mstatus
   localparam xlen_t SSTATUS_WMASK = SSTATUS_MASK & MSTATUS_WMASK;

   xlen_t mstatus_q;
   xlen_t mip_sw_q;
   xlen_t mscratch_q;
   xlen_t mcause_q;
   xlen_t mtval_q;
   xlen_t sscratch_q;
   xlen_t scause_q;
   xlen_t stval_q;

   xlen_t rd_val;
   logic  rd_known;
   logic  illegal;
   logic  wr_en;
   xlen_t wr_val;

   assign mip = (mip_sw_q & MIP_SW_MASK)
              | (xlen_t'(ext_intr) << IRQ_SEI)
              | (xlen_t'(timer_intr) << IRQ_MTI);

   //////////////////////////////////////////////////
   // read side

   always_comb begin
      rd_known = 1'b1;
      case (csr_addr)
         CSR_SSTATUS:  rd_val = mstatus_q & SSTATUS_MASK;
         CSR_SIE:      rd_val = mie & mideleg;
         CSR_STVEC:    rd_val = stvec;
         CSR_SSCRATCH: rd_val = sscratch_q;
         CSR_SEPC:     rd_val = sepc;
         CSR_SCAUSE:   rd_val = scause_q;
         CSR_STVAL:    rd_val = stval_q;
         CSR_SIP:      rd_val = mip & mideleg;
         CSR_SATP:     rd_val = satp;
         CSR_MSTATUS:  rd_val = mstatus_q;
         CSR_MISA:     rd_val = MISA_VALUE;
         CSR_MEDELEG:  rd_val = medeleg;
         CSR_MIDELEG:  rd_val = mideleg;
         CSR_MIE:      rd_val = mie;
         CSR_MTVEC:    rd_val = mtvec;
         CSR_MSCRATCH: rd_val = mscratch_q;
         CSR_MEPC:     rd_val = mepc;
         CSR_MCAUSE:   rd_val = mcause_q;
         CSR_MTVAL:    rd_val = mtval_q;
         CSR_MIP:      rd_val = mip;
         CSR_MHARTID:  rd_val = HART_ID;
         default: begin
            rd_val   = '0;
            rd_known = 1'b0;
         end
      endcase
   end

   // satp is trapped in S-mode while TVM is set
   assign illegal = !rd_known
                 || (csr_addr == CSR_SATP && mstatus_q[MS_TVM] && cpu_mode == PRIV_S);
   assign wr_en   = csr_valid && !illegal;

   always_comb begin
      case (csr_op)
         CSR_RW:  wr_val = csr_wdata;
         CSR_RS:  wr_val = rd_val | csr_wdata;
         CSR_RC:  wr_val = rd_val & ~csr_wdata;
         default: wr_val = rd_val;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         csr_done    <= 1'b0;
         csr_illegal <= 1'b0;
      end else begin
         csr_done    <= csr_valid;
         csr_illegal <= csr_valid && illegal;
      end
   end

   // old value goes back, zero on an illegal access
   always_ff @(posedge clk) begin
      csr_rdata <= illegal ? '0 : rd_val;
   end

   //////////////////////////////////////////////////
   // write side, traps and returns first

   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus_q  <= '0;
         mip_sw_q   <= '0;
         mscratch_q <= '0;
         mcause_q   <= '0;
         mtval_q    <= '0;
         sscratch_q <= '0;
         scause_q   <= '0;
         stval_q    <= '0;
         mtvec      <= '0;
         stvec      <= '0;
         mepc       <= '0;
         sepc       <= '0;
         medeleg    <= '0;
         mideleg    <= '0;
         mie        <= '0;
         satp       <= '0;
      end else if (trap_take && trap_to_s) begin
         sepc                <= trap_epc;
         scause_q            <= trap_cause;
         stval_q             <= trap_tval;
         mstatus_q[MS_SPP]   <= cpu_mode[0];
         mstatus_q[MS_SPIE]  <= mstatus_q[MS_SIE];
         mstatus_q[MS_SIE]   <= 1'b0;
      end else if (trap_take) begin
         mepc                <= trap_epc;
         mcause_q            <= trap_cause;
         mtval_q             <= trap_tval;
         mstatus_q[MS_MPP_HI:MS_MPP_LO] <= cpu_mode;
         mstatus_q[MS_MPIE]  <= mstatus_q[MS_MIE];
         mstatus_q[MS_MIE]   <= 1'b0;
      end else if (xret_m) begin
         mstatus_q[MS_MIE]   <= mstatus_q[MS_MPIE];
         mstatus_q[MS_MPIE]  <= 1'b1;
         mstatus_q[MS_MPP_HI:MS_MPP_LO] <= PRIV_U;
      end else if (xret_s) begin
         mstatus_q[MS_SIE]   <= mstatus_q[MS_SPIE];
         mstatus_q[MS_SPIE]  <= 1'b1;
         mstatus_q[MS_SPP]   <= 1'b0;
      end else if (wr_en) begin
         case (csr_addr)
            CSR_SSTATUS:
               mstatus_q <= (mstatus_q & ~SSTATUS_WMASK) | (wr_val & SSTATUS_WMASK);
            CSR_SIE:
               mie <= (mie & ~(mideleg & MIE_MASK)) | (wr_val & mideleg & MIE_MASK);
            CSR_SIP:
               mip_sw_q <= (mip_sw_q & ~(mideleg & MIP_SW_MASK))
                         | (wr_val & mideleg & MIP_SW_MASK);
            CSR_STVEC: begin
               // modes 2 and 3 are reserved, keep the old vector
               if (wr_val[1] == 1'b0) begin
                  stvec <= wr_val;
               end
            end
            CSR_SSCRATCH: sscratch_q <= wr_val;
            CSR_SEPC:     sepc <= wr_val;
            CSR_SCAUSE:   scause_q <= wr_val;
            CSR_STVAL:    stval_q <= wr_val;
            CSR_SATP:     satp <= wr_val;
            CSR_MSTATUS:
               mstatus_q <= (mstatus_q & ~MSTATUS_WMASK) | (wr_val & MSTATUS_WMASK);
            CSR_MEDELEG:  medeleg <= wr_val & MEDELEG_MASK;
            CSR_MIDELEG:  mideleg <= wr_val & MIDELEG_MASK;
            CSR_MIE:      mie <= wr_val & MIE_MASK;
            CSR_MTVEC: begin
               if (wr_val[1] == 1'b0) begin
                  mtvec <= wr_val;
               end
            end
            CSR_MSCRATCH: mscratch_q <= wr_val;
            CSR_MEPC:     mepc <= wr_val;
            CSR_MCAUSE:   mcause_q <= wr_val;
            CSR_MTVAL:    mtval_q <= wr_val;
            CSR_MIP:      mip_sw_q <= wr_val & MIP_SW_MASK;
            default: ;
         endcase
      end
   end

   assign mstatus_mie = mstatus_q[MS_MIE];
   assign mstatus_sie = mstatus_q[MS_SIE];
   assign mstatus_tvm = mstatus_q[MS_TVM];
   assign mstatus_mpp = priv_mode_t'(mstatus_q[MS_MPP_HI:MS_MPP_LO]);
   assign mstatus_spp = mstatus_q[MS_SPP];
   assign mxr         = mstatus_q[MS_MXR];
   assign sum         = mstatus_q[MS_SUM];

endmodule

//--- hdl/priv_pkg.sv
package priv_pkg;

   //////////////////////////////////////////////////
   // basic types

   typedef logic [31:0] xlen_t;
   typedef logic [11:0] csr_addr_t;
   typedef logic [4:0]  cause_t;

   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_mode_t;

   // same encoding as funct3[1:0] of the csr instructions
   typedef enum logic [1:0] {
      CSR_RW = 2'd1,
      CSR_RS = 2'd2,
      CSR_RC = 2'd3
   } csr_op_t;

   //////////////////////////////////////////////////
   // csr addresses

   localparam csr_addr_t CSR_SSTATUS  = 12'h100;
   localparam csr_addr_t CSR_SIE      = 12'h104;
   localparam csr_addr_t CSR_STVEC    = 12'h105;
   localparam csr_addr_t CSR_SSCRATCH = 12'h140;
   localparam csr_addr_t CSR_SEPC     = 12'h141;
   localparam csr_addr_t CSR_SCAUSE   = 12'h142;
   localparam csr_addr_t CSR_STVAL    = 12'h143;
   localparam csr_addr_t CSR_SIP      = 12'h144;
   localparam csr_addr_t CSR_SATP     = 12'h180;
   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MISA     = 12'h301;
   localparam csr_addr_t CSR_MEDELEG  = 12'h302;
   localparam csr_addr_t CSR_MIDELEG  = 12'h303;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;
   localparam csr_addr_t CSR_MIP      = 12'h344;
   localparam csr_addr_t CSR_MHARTID  = 12'hf14;

   //////////////////////////////////////////////////
   // interrupt numbers, masks and bit positions

   localparam int IRQ_SSI = 1;
   localparam int IRQ_MSI = 3;
   localparam int IRQ_MTI = 7;
   localparam int IRQ_SEI = 9;

   localparam xlen_t MSTATUS_WMASK = 32'h601e_79aa;
   localparam xlen_t SSTATUS_MASK  = 32'h800d_e133;
   localparam xlen_t MEDELEG_MASK  = 32'h0000_bfff;
   localparam xlen_t MIDELEG_MASK  = 32'h0000_0222;
   localparam xlen_t MIE_MASK      = 32'h0000_0aaa;
   // only the software bits are held in flops
   localparam xlen_t MIP_SW_MASK   = (32'd1 << IRQ_SSI) | (32'd1 << IRQ_MSI);

   // rv32 with a, i, m, s and u
   localparam xlen_t MISA_VALUE = 32'h4014_1101;

   localparam int MS_SIE    = 1;
   localparam int MS_MIE    = 3;
   localparam int MS_SPIE   = 5;
   localparam int MS_MPIE   = 7;
   localparam int MS_SPP    = 8;
   localparam int MS_MPP_LO = 11;
   localparam int MS_MPP_HI = 12;
   localparam int MS_SUM    = 18;
   localparam int MS_MXR    = 19;
   localparam int MS_TVM    = 20;

   localparam cause_t CAUSE_ILLEGAL = 5'd2;

endpackage
